//--- hdl/sxt_pkg.sv
// Coefficient constants and stream structs for the sample extraction join stage
package sxt_pkg;

  // ==============================
  // Coefficient constants
  // ==============================
  localparam int unsigned COEF_W    = 16;
  // Largest 16-bit prime, all coefficients below it
  localparam int unsigned MOD_Q     = 65521;
  localparam int unsigned QUARTER_N = 4;
  localparam int unsigned HALF_N    = 8;
  // Rotation amount, 0 to 2*QUARTER_N-1
  localparam int unsigned ROT_W     = 3;

  // ==============================
  // Data words
  // ==============================
  typedef logic [COEF_W-1:0] coef_t;
  typedef coef_t [QUARTER_N-1:0] quarter_t;
  typedef coef_t [HALF_N-1:0] half_t;

  // Opaque command tag, carried untouched to the output
  typedef struct packed {
    logic [7:0] blwe_id;
    logic       last;
  } cmd_t;

  // Last two permutation levels
  typedef struct packed {
    logic lvl1;
    logic lvl2;
  } perm_t;

  // ==============================
  // Stream payloads
  // ==============================
  typedef struct packed {
    quarter_t             coefs;
    logic [ROT_W-1:0]     rot;
  } lane_in_t;

  // Side info riding along lane 1
  typedef struct packed {
    cmd_t  cmd;
    perm_t perm;
  } lane1_side_t;

  // Join FIFO entry
  typedef struct packed {
    half_t data;
    cmd_t  cmd;
    logic  lvl2;
  } join_word_t;

  typedef struct packed {
    half_t data;
    cmd_t  cmd;
  } out_word_t;

endpackage

//--- hdl/sxt_rot_lane.sv
// Input lane: negacyclic rotation of a quarter word with modular negation, one pipe register
`timescale 1ns/1ps

module sxt_rot_lane (
  input  logic                clk,
  input  logic                s_rst_n,
  input  sxt_pkg::lane_in_t   in_word,
  input  sxt_pkg::lane1_side_t in_side,
  input  logic                in_vld,
  output logic                in_rdy,
  output sxt_pkg::quarter_t   out_data,
  output sxt_pkg::lane1_side_t out_side,
  output logic                out_vld,
  input  logic                out_rdy
);

  // Modular negate, zero stays zero
  function automatic sxt_pkg::coef_t mod_neg(input sxt_pkg::coef_t v);
    sxt_pkg::coef_t r;
    if (v == '0) r = '0;
    else         r = sxt_pkg::coef_t'(sxt_pkg::MOD_Q - v);
    return r;
  endfunction

  // ==============================
  // Rotation by b
  // ==============================
  sxt_pkg::quarter_t rot_data;

  always_comb begin
    int unsigned pos;
    for (int i = 0; i < sxt_pkg::QUARTER_N; i++) begin
      // Position in the 2*QUARTER_N negacyclic ring
      pos = (i + 2 * sxt_pkg::QUARTER_N - int'(in_word.rot)) % (2 * sxt_pkg::QUARTER_N);
      if (pos >= sxt_pkg::QUARTER_N)
        rot_data[i] = mod_neg(in_word.coefs[pos - sxt_pkg::QUARTER_N]);
      else
        rot_data[i] = in_word.coefs[pos];
    end
  end

  // ==============================
  // Pipe register
  // ==============================
  // Take a word when empty or when current one leaves
  assign in_rdy = ~out_vld | out_rdy;

  always_ff @(posedge clk) begin
    if (!s_rst_n) out_vld <= 1'b0;
    else if (in_rdy) out_vld <= in_vld;
  end

  // Payload follows the handshake, held while stalled
  always_ff @(posedge clk) begin
    if (in_vld && in_rdy) begin
      out_data <= rot_data;
      out_side <= in_side;
    end
  end

endmodule

//--- hdl/sxt_credit.sv
// Credit counter limiting lane-1 words in flight to the join FIFO depth
`timescale 1ns/1ps

module sxt_credit #(
  parameter int JOIN_FIFO_DEPTH = 4
) (
  input  logic clk,
  input  logic s_rst_n,
  input  logic up_vld,
  output logic up_rdy,
  output logic dn_vld,
  input  logic dn_rdy,
  input  logic buf_cnt_do_dec
);

  localparam int CNT_W = $clog2(JOIN_FIFO_DEPTH + 1);

  // Words accepted, not yet read out of the join FIFO
  logic [CNT_W-1:0] cnt;
  logic             has_credit;
  logic             do_inc;

  assign has_credit = (cnt != CNT_W'(JOIN_FIFO_DEPTH));

  // Handshake passes through only with a free slot
  assign dn_vld = up_vld & has_credit;
  assign up_rdy = dn_rdy & has_credit;
  assign do_inc = up_vld & up_rdy;

  always_ff @(posedge clk) begin
    if (!s_rst_n) begin
      cnt <= '0;
    end else begin
      case ({do_inc, buf_cnt_do_dec})
        2'b10:   cnt <= cnt + 1'b1;
        2'b01:   cnt <= cnt - 1'b1;
        default: cnt <= cnt;
      endcase
    end
  end

  // A FIFO read always belongs to a word counted earlier
  a_no_underflow: assert property (@(posedge clk) disable iff (!s_rst_n)
    buf_cnt_do_dec |-> (cnt != '0));

endmodule

//--- hdl/sxt_fifo.sv
// Circular-buffer FIFO of join words with valid/ready on both sides
`timescale 1ns/1ps

module sxt_fifo #(
  parameter int DEPTH = 4
) (
  input  logic                clk,
  input  logic                s_rst_n,
  input  sxt_pkg::join_word_t in_data,
  input  logic                in_vld,
  output logic                in_rdy,
  output sxt_pkg::join_word_t out_data,
  output logic                out_vld,
  input  logic                out_rdy
);

  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);

  sxt_pkg::join_word_t mem [DEPTH];
  logic [PTR_W-1:0]    wr_ptr;
  logic [PTR_W-1:0]    rd_ptr;
  logic [CNT_W-1:0]    count;
  logic                wr_en;
  logic                rd_en;

  assign in_rdy  = (count != CNT_W'(DEPTH));
  assign out_vld = (count != '0);
  // Head slot comes straight from the storage flops
  assign out_data = mem[rd_ptr];

  assign wr_en = in_vld & in_rdy;
  assign rd_en = out_vld & out_rdy;

  // Pointers wrap at DEPTH, any depth allowed
  always_ff @(posedge clk) begin
    if (!s_rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (wr_en) wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      if (rd_en) rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      if (wr_en != rd_en) count <= wr_en ? count + 1'b1 : count - 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (wr_en) mem[wr_ptr] <= in_data;
  end

  // Writer never offers a word while every slot is taken
  a_no_full_write: assert property (@(posedge clk) disable iff (!s_rst_n)
    (count == CNT_W'(DEPTH)) |-> !in_vld);

endmodule

//--- hdl/sxt_join.sv
// Join of the two lanes: lane-0 delay, pairing with level-1 swap, pair register and join FIFO
`timescale 1ns/1ps

module sxt_join #(
  parameter int JOIN_FIFO_DEPTH = 4
) (
  input  logic                 clk,
  input  logic                 s_rst_n,
  input  sxt_pkg::quarter_t    in0_data,
  input  logic                 in0_vld,
  output logic                 in0_rdy,
  input  sxt_pkg::quarter_t    in1_data,
  input  sxt_pkg::lane1_side_t in1_side,
  input  logic                 in1_vld,
  output logic                 in1_rdy,
  output sxt_pkg::join_word_t  out_word,
  output logic                 out_vld,
  input  logic                 out_rdy,
  output logic                 buf_cnt_do_dec
);

  // ==============================
  // Lane 0 delay element
  // ==============================
  sxt_pkg::quarter_t d0_data;
  logic              d0_vld;
  logic              d0_rdy;

  assign in0_rdy = ~d0_vld | d0_rdy;

  always_ff @(posedge clk) begin
    if (!s_rst_n) d0_vld <= 1'b0;
    else if (in0_rdy) d0_vld <= in0_vld;
  end

  always_ff @(posedge clk) begin
    if (in0_vld && in0_rdy) d0_data <= in0_data;
  end

  // ==============================
  // Pairing and level-1 swap
  // ==============================
  sxt_pkg::join_word_t pair_word;
  logic                pair_vld;
  logic                pair_rdy;

  // Fire only with both sides present
  assign pair_vld = d0_vld & in1_vld;
  assign d0_rdy   = in1_vld & pair_rdy;
  assign in1_rdy  = d0_vld & pair_rdy;

  // Lane 0 low quarter by default, exchanged on lvl1
  assign pair_word.data = in1_side.perm.lvl1 ? {d0_data, in1_data} : {in1_data, d0_data};
  assign pair_word.cmd  = in1_side.cmd;
  assign pair_word.lvl2 = in1_side.perm.lvl2;

  // Pair register
  sxt_pkg::join_word_t pr_word;
  logic                pr_vld;
  logic                fifo_in_rdy;

  assign pair_rdy = ~pr_vld | fifo_in_rdy;

  always_ff @(posedge clk) begin
    if (!s_rst_n) pr_vld <= 1'b0;
    else if (pair_rdy) pr_vld <= pair_vld;
  end

  always_ff @(posedge clk) begin
    if (pair_vld && pair_rdy) pr_word <= pair_word;
  end

  // ==============================
  // Join FIFO
  // ==============================
  sxt_fifo #(
    .DEPTH (JOIN_FIFO_DEPTH)
  ) join_fifo (
    .clk      (clk),
    .s_rst_n  (s_rst_n),
    .in_data  (pr_word),
    .in_vld   (pr_vld),
    .in_rdy   (fifo_in_rdy),
    .out_data (out_word),
    .out_vld  (out_vld),
    .out_rdy  (out_rdy)
  );

  // Read strobe one cycle late, returns a credit
  always_ff @(posedge clk) begin
    if (!s_rst_n) buf_cnt_do_dec <= 1'b0;
    else buf_cnt_do_dec <= out_vld & out_rdy;
  end

  // Upstream credits keep a slot free for every pending pair
  a_no_fifo_block: assert property (@(posedge clk) disable iff (!s_rst_n)
    pr_vld |-> fifo_in_rdy);

endmodule

//--- hdl/sxt_order_out.sv
// Output stage: level-2 reversal of the half word into a valid/ready output register
`timescale 1ns/1ps

module sxt_order_out (
  input  logic                clk,
  input  logic                s_rst_n,
  input  sxt_pkg::join_word_t in_word,
  input  logic                in_vld,
  output logic                in_rdy,
  output sxt_pkg::out_word_t  out_word,
  output logic                out_vld,
  input  logic                out_rdy
);

  sxt_pkg::half_t rev_data;

  // Coefficient i goes to HALF_N-1-i
  always_comb begin
    for (int i = 0; i < sxt_pkg::HALF_N; i++) begin
      rev_data[i] = in_word.data[sxt_pkg::HALF_N - 1 - i];
    end
  end

  // Accept when empty or when the held word leaves
  assign in_rdy = ~out_vld | out_rdy;

  always_ff @(posedge clk) begin
    if (!s_rst_n) out_vld <= 1'b0;
    else if (in_rdy) out_vld <= in_vld;
  end

  always_ff @(posedge clk) begin
    if (in_vld && in_rdy) begin
      out_word.data <= in_word.lvl2 ? rev_data : in_word.data;
      out_word.cmd  <= in_word.cmd;
    end
  end

  // Held word stays put under back-pressure
  a_out_stable: assert property (@(posedge clk) disable iff (!s_rst_n)
    out_vld && !out_rdy |=> $stable(out_word));

endmodule

//--- hdl/sxt_top.sv
// Top level: credit counter, two rotation lanes, join with FIFO and output order stage
`timescale 1ns/1ps

module sxt_top #(
  parameter int JOIN_FIFO_DEPTH = 4
) (
  input  logic                 clk,
  input  logic                 s_rst_n,
  input  sxt_pkg::lane_in_t    in0_word,
  input  logic                 in0_vld,
  output logic                 in0_rdy,
  input  sxt_pkg::lane_in_t    in1_word,
  input  sxt_pkg::lane1_side_t in1_side,
  input  logic                 in1_vld,
  output logic                 in1_rdy,
  output sxt_pkg::out_word_t   out_word,
  output logic                 out_vld,
  input  logic                 out_rdy
);

  // ==============================
  // Input side
  // ==============================
  logic                 c1_vld;
  logic                 c1_rdy;
  logic                 buf_cnt_do_dec;
  sxt_pkg::quarter_t    r0_data;
  logic                 r0_vld;
  logic                 r0_rdy;
  sxt_pkg::quarter_t    r1_data;
  sxt_pkg::lane1_side_t r1_side;
  logic                 r1_vld;
  logic                 r1_rdy;

  sxt_credit #(
    .JOIN_FIFO_DEPTH (JOIN_FIFO_DEPTH)
  ) credit_i (
    .clk            (clk),
    .s_rst_n        (s_rst_n),
    .up_vld         (in1_vld),
    .up_rdy         (in1_rdy),
    .dn_vld         (c1_vld),
    .dn_rdy         (c1_rdy),
    .buf_cnt_do_dec (buf_cnt_do_dec)
  );

  // Lane 0 has no side info
  sxt_rot_lane lane0_i (
    .clk      (clk),
    .s_rst_n  (s_rst_n),
    .in_word  (in0_word),
    .in_side  ('0),
    .in_vld   (in0_vld),
    .in_rdy   (in0_rdy),
    .out_data (r0_data),
    .out_side (),
    .out_vld  (r0_vld),
    .out_rdy  (r0_rdy)
  );

  sxt_rot_lane lane1_i (
    .clk      (clk),
    .s_rst_n  (s_rst_n),
    .in_word  (in1_word),
    .in_side  (in1_side),
    .in_vld   (c1_vld),
    .in_rdy   (c1_rdy),
    .out_data (r1_data),
    .out_side (r1_side),
    .out_vld  (r1_vld),
    .out_rdy  (r1_rdy)
  );

  // ==============================
  // Join and output side
  // ==============================
  sxt_pkg::join_word_t j_word;
  logic                j_vld;
  logic                j_rdy;

  sxt_join #(
    .JOIN_FIFO_DEPTH (JOIN_FIFO_DEPTH)
  ) join_i (
    .clk            (clk),
    .s_rst_n        (s_rst_n),
    .in0_data       (r0_data),
    .in0_vld        (r0_vld),
    .in0_rdy        (r0_rdy),
    .in1_data       (r1_data),
    .in1_side       (r1_side),
    .in1_vld        (r1_vld),
    .in1_rdy        (r1_rdy),
    .out_word       (j_word),
    .out_vld        (j_vld),
    .out_rdy        (j_rdy),
    .buf_cnt_do_dec (buf_cnt_do_dec)
  );

  sxt_order_out order_i (
    .clk      (clk),
    .s_rst_n  (s_rst_n),
    .in_word  (j_word),
    .in_vld   (j_vld),
    .in_rdy   (j_rdy),
    .out_word (out_word),
    .out_vld  (out_vld),
    .out_rdy  (out_rdy)
  );

endmodule

//--- verif/sxt_tb.sv
// Testbench for the join stage: clock, reset, lane drivers, reference queue, assertions, watchdog
`timescale 1ns/1ps

module sxt_tb;

  localparam int JOIN_FIFO_DEPTH = 4;
  localparam int CLK_PERIOD      = 40;
  // Words per lane over all phases: sweep, swap, lvl2, random, stall
  localparam int TOTAL_WORDS     = 32 + 16 + 32 + 200 + 12;
  localparam int WATCHDOG_NS     = TOTAL_WORDS * 20 * CLK_PERIOD;

  logic                 clk;
  logic                 s_rst_n;
  sxt_pkg::lane_in_t    in0_word;
  logic                 in0_vld;
  logic                 in0_rdy;
  sxt_pkg::lane_in_t    in1_word;
  sxt_pkg::lane1_side_t in1_side;
  logic                 in1_vld;
  logic                 in1_rdy;
  sxt_pkg::out_word_t   out_word;
  logic                 out_vld;
  logic                 out_rdy;

  // Reference model state
  sxt_pkg::quarter_t    q0[$];
  sxt_pkg::quarter_t    q1[$];
  sxt_pkg::lane1_side_t s1[$];
  sxt_pkg::out_word_t   exp_q[$];
  sxt_pkg::out_word_t   exp_head;
  logic                 exp_avail = 1'b0;
  int acc0 = 0;
  int acc1 = 0;
  int out_cnt = 0;
  int stall_acc = 0;
  int errors = 0;
  int rdy_pct = 100;
  logic idle_chk = 1'b0;
  logic stall_on = 1'b0;
  string test_name = "reset";

  sxt_top #(
    .JOIN_FIFO_DEPTH (JOIN_FIFO_DEPTH)
  ) sxt_top_i (
    .clk      (clk),
    .s_rst_n  (s_rst_n),
    .in0_word (in0_word),
    .in0_vld  (in0_vld),
    .in0_rdy  (in0_rdy),
    .in1_word (in1_word),
    .in1_side (in1_side),
    .in1_vld  (in1_vld),
    .in1_rdy  (in1_rdy),
    .out_word (out_word),
    .out_vld  (out_vld),
    .out_rdy  (out_rdy)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  // ==============================
  // Reference model
  // ==============================
  // Out i takes in (i+8-b) mod 4, negated when (i+8-b) mod 8 >= 4
  function automatic sxt_pkg::quarter_t ref_rotate(input sxt_pkg::lane_in_t w);
    sxt_pkg::quarter_t q;
    sxt_pkg::coef_t    v;
    int                src;
    for (int i = 0; i < 4; i++) begin
      src = i + 8 - int'(w.rot);
      v = w.coefs[src % 4];
      if ((src % 8) >= 4 && v != 0) v = sxt_pkg::coef_t'(sxt_pkg::MOD_Q - v);
      q[i] = v;
    end
    return q;
  endfunction

  // Swap quarters on lvl1, then reverse all eight on lvl2
  function automatic sxt_pkg::out_word_t ref_join(input sxt_pkg::quarter_t a,
                                                  input sxt_pkg::quarter_t b,
                                                  input sxt_pkg::lane1_side_t side);
    sxt_pkg::half_t     h;
    sxt_pkg::out_word_t o;
    for (int i = 0; i < 4; i++) begin
      h[i]     = side.perm.lvl1 ? b[i] : a[i];
      h[i + 4] = side.perm.lvl1 ? a[i] : b[i];
    end
    for (int i = 0; i < 8; i++) o.data[i] = side.perm.lvl2 ? h[7 - i] : h[i];
    o.cmd = side.cmd;
    return o;
  endfunction

  always @(posedge clk) begin
    if (s_rst_n) begin
      if (in0_vld && in0_rdy) begin
        q0.push_back(ref_rotate(in0_word));
        acc0++;
      end
      if (in1_vld && in1_rdy) begin
        q1.push_back(ref_rotate(in1_word));
        s1.push_back(in1_side);
        acc1++;
        stall_acc++;
      end
      // Pairs form in arrival order
      while (q0.size() != 0 && q1.size() != 0)
        exp_q.push_back(ref_join(q0.pop_front(), q1.pop_front(), s1.pop_front()));
      if (out_vld && out_rdy) begin
        if (exp_q.size() != 0) void'(exp_q.pop_front());
        out_cnt++;
      end
      exp_avail = (exp_q.size() != 0);
      exp_head  = exp_avail ? exp_q[0] : '0;
    end
  end

  // ==============================
  // Checks
  // ==============================
  a_out_match: assert property (@(posedge clk) disable iff (!s_rst_n)
    out_vld && out_rdy && exp_avail |-> out_word == exp_head)
    else begin
      errors++;
      $display("mismatch %s: expected %h actual %h", test_name,
               $sampled(exp_head), $sampled(out_word));
    end

  a_out_expected: assert property (@(posedge clk) disable iff (!s_rst_n)
    out_vld && out_rdy |-> exp_avail)
    else begin
      errors++;
      $display("%s: output word arrived while none was expected", test_name);
    end

  a_idle: assert property (@(posedge clk) disable iff (!s_rst_n)
    idle_chk |-> !out_vld && in1_rdy)
    else begin
      errors++;
      $display("after reset out_vld is high or in1_rdy is low");
    end

  // One word may sit in the output register past its FIFO read
  a_in_flight: assert property (@(posedge clk) disable iff (!s_rst_n)
    (acc1 - out_cnt) <= JOIN_FIFO_DEPTH + 1)
    else begin
      errors++;
      $display("%s: lane-1 words in flight exceed the join FIFO depth", test_name);
    end

  a_stall_limit: assert property (@(posedge clk) disable iff (!s_rst_n)
    stall_on |-> stall_acc <= JOIN_FIFO_DEPTH + 3)
    else begin
      errors++;
      $display("in1 kept accepting words during the output stall");
    end

  // ==============================
  // Stimulus
  // ==============================
  always @(negedge clk) out_rdy <= (($urandom % 100) < rdy_pct);

  // Zeros and q-1 show up often, the rest uniform below q
  function automatic sxt_pkg::lane_in_t make_word(input int idx, input bit sweep);
    sxt_pkg::lane_in_t w;
    int                pick;
    for (int i = 0; i < 4; i++) begin
      pick = $urandom % 4;
      if (pick == 0) w.coefs[i] = '0;
      else if (pick == 1) w.coefs[i] = sxt_pkg::coef_t'(sxt_pkg::MOD_Q - 1);
      else w.coefs[i] = sxt_pkg::coef_t'($urandom % sxt_pkg::MOD_Q);
    end
    w.rot = sweep ? 3'(idx) : 3'($urandom);
    return w;
  endfunction

  // 0 none, 1 swap, 2 reverse, 3 both, else random
  function automatic sxt_pkg::perm_t make_perm(input int mode);
    sxt_pkg::perm_t p;
    p.lvl1 = (mode == 1 || mode == 3) ? 1'b1 : (mode > 3) ? 1'($urandom) : 1'b0;
    p.lvl2 = (mode == 2 || mode == 3) ? 1'b1 : (mode > 3) ? 1'($urandom) : 1'b0;
    return p;
  endfunction

  // Word held until the model counts its transfer
  task automatic drive_lane0(input int n, input int vld_pct, input bit sweep);
    int base;
    int k;
    base = acc0;
    k = 0;
    while (acc0 - base < n) begin
      @(negedge clk);
      if (!(in0_vld && acc0 - base < k)) begin
        if (k == n || ($urandom % 100) >= vld_pct) begin
          in0_vld = 1'b0;
        end else begin
          in0_word = make_word(k, sweep);
          in0_vld = 1'b1;
          k++;
        end
      end
    end
  endtask

  task automatic drive_lane1(input int n, input int vld_pct, input int mode, input bit sweep);
    int base;
    int k;
    base = acc1;
    k = 0;
    while (acc1 - base < n) begin
      @(negedge clk);
      if (!(in1_vld && acc1 - base < k)) begin
        if (k == n || ($urandom % 100) >= vld_pct) begin
          in1_vld = 1'b0;
        end else begin
          in1_word = make_word(k + 3, sweep);
          in1_side.cmd.blwe_id = 8'(k);
          in1_side.cmd.last = (k == n - 1);
          in1_side.perm = make_perm(mode);
          in1_vld = 1'b1;
          k++;
        end
      end
    end
  endtask

  task automatic wait_drain();
    while (out_cnt != acc1 || acc0 != acc1) @(negedge clk);
  endtask

  task automatic run_phase(input string name, input int n, input int p0, input int p1,
                           input int rdy, input int mode, input bit sweep);
    @(posedge clk);
    test_name = name;
    rdy_pct = rdy;
    fork
      drive_lane0(n, p0, sweep);
      drive_lane1(n, p1, mode, sweep);
    join
    wait_drain();
  endtask

  initial begin
    void'($urandom(85364));
    s_rst_n  = 1'b0;
    in0_word = '0;
    in0_vld  = 1'b0;
    in1_word = '0;
    in1_side = '0;
    in1_vld  = 1'b0;
    out_rdy  = 1'b1;
    repeat (2) @(posedge clk);
    @(negedge clk);
    s_rst_n  = 1'b1;
    idle_chk = 1'b1;
    repeat (3) @(negedge clk);
    idle_chk = 1'b0;

    run_phase("rotate_sweep", 32, 100, 100, 100, 0, 1'b1);
    run_phase("swap_lvl1", 16, 100, 100, 100, 1, 1'b0);
    run_phase("reverse_lvl2", 16, 100, 100, 100, 2, 1'b0);
    run_phase("swap_reverse", 16, 100, 100, 100, 3, 1'b0);
    run_phase("random_skew", 200, 60, 40, 50, 4, 1'b0);

    // Long output stall, then release
    test_name = "output_stall";
    stall_acc = 0;
    @(posedge clk);
    rdy_pct  = 0;
    stall_on = 1'b1;
    fork
      drive_lane0(12, 100, 1'b0);
      drive_lane1(12, 100, 4, 1'b0);
    join_none
    repeat (40) @(negedge clk);
    assert (!in1_rdy) else begin
      errors++;
      $display("in1_rdy still high after a long output stall");
    end
    @(posedge clk);
    stall_on = 1'b0;
    rdy_pct  = 70;
    wait fork;
    wait_drain();

    assert (exp_q.size() == 0 && q0.size() == 0 && q1.size() == 0) else begin
      errors++;
      $display("expected words left over at the end of the run");
    end
    $display("errors: %0d, words checked: %0d", errors, out_cnt);
    if (errors == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

  // Watchdog sized from the word count
  initial begin
    #(WATCHDOG_NS);
    $display("timeout after %0d ns, errors: %0d, words checked: %0d",
             WATCHDOG_NS, errors, out_cnt);
    $display("Verification failed");
    $finish;
  end

endmodule

//--- verilog.f
hdl/sxt_pkg.sv
hdl/sxt_rot_lane.sv
hdl/sxt_credit.sv
hdl/sxt_fifo.sv
hdl/sxt_join.sv
hdl/sxt_order_out.sv
hdl/sxt_top.sv
verif/sxt_tb.sv

//--- Bender.yml
package:
  name: sxt_join_stage

sources:
  - files:
      - hdl/sxt_pkg.sv
      - hdl/sxt_rot_lane.sv
      - hdl/sxt_credit.sv
      - hdl/sxt_fifo.sv
      - hdl/sxt_join.sv
      - hdl/sxt_order_out.sv
      - hdl/sxt_top.sv
  - target: test
    files:
      - verif/sxt_tb.sv
